// ==== Bender.yml ====
package:
  name: adc_trigger

sources:
  - files:
      - adc_trig_pkg.sv
      - trig_event_if.sv
      - exec_state_ctrl.sv
      - base_calc.sv
      - threshold_detect.sv
      - event_fifo.sv
      - adc_trigger_top.sv
  - target: test
    files:
      - tb_adc_trigger_top.sv

// ==== adc_trig_pkg.sv ====
package adc_trig_pkg;

    // stream format from the RF data converter
    localparam int TDATA_WIDTH = 128;
    localparam int LANE_WIDTH  = 16;
    localparam int LANES       = 8;
    localparam int ADC_WIDTH   = 12;

    // number of accepted beats folded into the baseline
    localparam int BASELINE_CALC_LEN = 16;

    // trigger level above baseline, percent of full scale
    localparam int THRESHOLD_PCT    = 10;
    localparam int THRESHOLD_COUNTS = ((1 << ADC_WIDTH) * THRESHOLD_PCT) / 100;

    localparam int EVENT_FIFO_DEPTH = 4;

    typedef logic [ADC_WIDTH-1:0] sample_t;

    // eight 12-bit samples need three extra bits
    typedef logic [ADC_WIDTH+$clog2(LANES)-1:0] beat_sum_t;

    typedef logic [$clog2(LANES)-1:0] lane_idx_t;

    typedef logic [31:0] timestamp_t;

    typedef logic [$clog2(BASELINE_CALC_LEN+1)-1:0] calc_cnt_t;

    // INIT is the baseline calculation, TRG is armed
    typedef enum logic [1:0] {
        EXEC_INIT = 2'b00,
        EXEC_IDLE = 2'b01,
        EXEC_TRG  = 2'b11
    } exec_state_t;

endpackage

// ==== adc_trigger_top.sv ====
`timescale 1ns/10ps

module adc_trigger_top (
    input  logic                                 AXIS_ACLK,
    input  logic                                 AXIS_ARESETN,
    input  logic [adc_trig_pkg::TDATA_WIDTH-1:0] s_axis_tdata,
    input  logic                                 s_axis_tvalid,
    output logic                                 s_axis_tready,
    input  logic                                 start,
    input  logic                                 arm,
    output adc_trig_pkg::sample_t                baseline,
    output logic                                 calc_complete,
    output logic                                 m_event_valid,
    input  logic                                 m_event_ready,
    output adc_trig_pkg::timestamp_t             m_event_timestamp,
    output adc_trig_pkg::lane_idx_t              m_event_lane,
    output adc_trig_pkg::sample_t                m_event_sample
);
    import adc_trig_pkg::*;

    exec_state_t exec_state;
    logic        beat_accept;

    // shared by the averager, the detector decides tready
    assign beat_accept = s_axis_tvalid & s_axis_tready;

    trig_event_if evt_if ();

    exec_state_ctrl exec_state_ctrl_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .start         (start),
        .arm           (arm),
        .calc_complete (calc_complete),
        .exec_state    (exec_state)
    );

    base_calc base_calc_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .exec_state    (exec_state),
        .tdata         (s_axis_tdata),
        .beat_accept   (beat_accept),
        .baseline      (baseline),
        .calc_complete (calc_complete)
    );

    threshold_detect threshold_detect_inst (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .tdata        (s_axis_tdata),
        .tvalid       (s_axis_tvalid),
        .tready       (s_axis_tready),
        .baseline     (baseline),
        .evt          (evt_if.src)
    );

    event_fifo event_fifo_inst (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .evt          (evt_if.dst),
        .m_valid      (m_event_valid),
        .m_ready      (m_event_ready),
        .m_timestamp  (m_event_timestamp),
        .m_lane       (m_event_lane),
        .m_sample     (m_event_sample)
    );

endmodule

// ==== base_calc.sv ====
`timescale 1ns/10ps

module base_calc (
    input  logic                                 AXIS_ACLK,
    input  logic                                 AXIS_ARESETN,
    input  adc_trig_pkg::exec_state_t            exec_state,
    input  logic [adc_trig_pkg::TDATA_WIDTH-1:0] tdata,
    input  logic                                 beat_accept,
    output adc_trig_pkg::sample_t                baseline,
    output logic                                 calc_complete
);
    import adc_trig_pkg::*;

    beat_sum_t   beat_sum;
    sample_t     avg;
    sample_t     avg_next;
    calc_cnt_t   cnt;
    calc_cnt_t   cnt_base;
    exec_state_t state_d;
    logic        first_cycle;
    logic        take_beat;

    // sum of the low 12 bits of every lane
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < LANES; i++)
        begin
            beat_sum = beat_sum + beat_sum_t'(tdata[i*LANE_WIDTH +: ADC_WIDTH]);
        end
    end

    // first cycle of INIT restarts the count
    assign first_cycle = (exec_state == EXEC_INIT) && (state_d != EXEC_INIT);
    assign cnt_base    = first_cycle ? '0 : cnt;
    assign take_beat   = beat_accept && (exec_state == EXEC_INIT) &&
                         (cnt_base < calc_cnt_t'(BASELINE_CALC_LEN));

    // recursive halving average, floors at every step
    always_comb
    begin
        if (cnt_base == '0)
            avg_next = sample_t'(beat_sum / LANES);
        else
            avg_next = sample_t'((avg >> 1) + (beat_sum / (2 * LANES)));
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            cnt           <= '0;
            calc_complete <= 1'b0;
            baseline      <= '0;
            state_d       <= EXEC_IDLE;
        end
        else
        begin
            state_d <= exec_state;
            if (first_cycle)
            begin
                cnt           <= '0;
                calc_complete <= 1'b0;
            end
            if (take_beat)
            begin
                cnt <= cnt_base + 1'b1;
                if (cnt_base == calc_cnt_t'(BASELINE_CALC_LEN - 1))
                begin
                    baseline      <= avg_next;
                    calc_complete <= 1'b1;
                end
            end
        end
    end

    // running average, only meaningful while counting
    always_ff @(posedge AXIS_ACLK)
    begin
        if (take_beat)
            avg <= avg_next;
    end

    a_cnt_in_range : assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        cnt <= calc_cnt_t'(BASELINE_CALC_LEN)
    );

endmodule

// ==== compile.f ====
adc_trig_pkg.sv
trig_event_if.sv
exec_state_ctrl.sv
base_calc.sv
threshold_detect.sv
event_fifo.sv
adc_trigger_top.sv
tb_adc_trigger_top.sv

// ==== event_fifo.sv ====
`timescale 1ns/10ps

module event_fifo (
    input  logic                     AXIS_ACLK,
    input  logic                     AXIS_ARESETN,
    trig_event_if.dst                evt,
    output logic                     m_valid,
    input  logic                     m_ready,
    output adc_trig_pkg::timestamp_t m_timestamp,
    output adc_trig_pkg::lane_idx_t  m_lane,
    output adc_trig_pkg::sample_t    m_sample
);
    import adc_trig_pkg::*;

    timestamp_t                              ts_mem [EVENT_FIFO_DEPTH];
    lane_idx_t                               lane_mem [EVENT_FIFO_DEPTH];
    sample_t                                 sample_mem [EVENT_FIFO_DEPTH];
    logic [$clog2(EVENT_FIFO_DEPTH)-1:0]     wr_ptr;
    logic [$clog2(EVENT_FIFO_DEPTH)-1:0]     rd_ptr;
    logic [$clog2(EVENT_FIFO_DEPTH+1)-1:0]   count;
    logic                                    push;
    logic                                    pop;

    assign evt.ready = (count != EVENT_FIFO_DEPTH);
    assign push      = evt.valid && evt.ready;
    assign m_valid   = (count != '0);
    assign pop       = m_valid && m_ready;

    // head of queue straight from storage
    assign m_timestamp = ts_mem[rd_ptr];
    assign m_lane      = lane_mem[rd_ptr];
    assign m_sample    = sample_mem[rd_ptr];

    always_ff @(posedge AXIS_ACLK)
    begin
        if (push)
        begin
            ts_mem[wr_ptr]     <= evt.timestamp;
            lane_mem[wr_ptr]   <= evt.lane;
            sample_mem[wr_ptr] <= evt.sample;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    a_count_in_range : assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        count <= EVENT_FIFO_DEPTH
    );

endmodule

// ==== exec_state_ctrl.sv ====
`timescale 1ns/10ps

module exec_state_ctrl (
    input  logic                      AXIS_ACLK,
    input  logic                      AXIS_ARESETN,
    input  logic                      start,
    input  logic                      arm,
    input  logic                      calc_complete,
    output adc_trig_pkg::exec_state_t exec_state
);
    import adc_trig_pkg::*;

    exec_state_t state;
    exec_state_t state_next;
    logic        calc_complete_d;
    logic        calc_rise;

    // a stale flag from the previous run must not end a new calculation,
    // so only the rising edge counts
    assign calc_rise = calc_complete && !calc_complete_d;

    always_comb
    begin
        state_next = state;
        if (start)
        begin
            state_next = EXEC_INIT;
        end
        else
        begin
            case (state)
                EXEC_INIT:
                begin
                    if (calc_rise)
                        state_next = EXEC_IDLE;
                end
                EXEC_IDLE:
                begin
                    if (arm && calc_complete)
                        state_next = EXEC_TRG;
                end
                EXEC_TRG:
                begin
                    if (!arm)
                        state_next = EXEC_IDLE;
                end
                default:
                    state_next = EXEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            state           <= EXEC_IDLE;
            calc_complete_d <= 1'b0;
        end
        else
        begin
            state           <= state_next;
            calc_complete_d <= calc_complete;
        end
    end

    assign exec_state = state;

    // armed operation relies on a finished baseline for its whole duration
    a_trg_needs_baseline : assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (state == EXEC_TRG) |-> calc_complete
    );

endmodule

// ==== tb_adc_trigger_top.sv ====
`timescale 1ns/10ps

module tb_adc_trigger_top;
    import adc_trig_pkg::*;

    localparam int NUM_PHASES = 7;
    localparam int CALC_LEN   = 16;
    localparam int HIT_MARGIN = 409;

    logic                   AXIS_ACLK;
    logic                   AXIS_ARESETN;
    logic [TDATA_WIDTH-1:0] s_axis_tdata;
    logic                   s_axis_tvalid;
    logic                   s_axis_tready;
    logic                   start;
    logic                   arm;
    sample_t                baseline;
    logic                   calc_complete;
    logic                   m_event_valid;
    logic                   m_event_ready;
    timestamp_t             m_event_timestamp;
    lane_idx_t              m_event_lane;
    sample_t                m_event_sample;

    // phase table
    string       ph_name [NUM_PHASES];
    bit          ph_start [NUM_PHASES];
    bit          ph_arm [NUM_PHASES];
    int          ph_level [NUM_PHASES];
    int          ph_noise [NUM_PHASES];
    int          ph_beats [NUM_PHASES];
    logic [7:0]  ph_mask [NUM_PHASES];
    int          ph_spike_off [NUM_PHASES];
    int          ph_spike_at [NUM_PHASES];
    int          ph_spike_cnt [NUM_PHASES];
    bit          ph_hold [NUM_PHASES];
    bit          ph_gaps [NUM_PHASES];
    int          total_beats;
    bit          table_ready;

    // reference model state
    logic [31:0] seed;
    string       cur_name;
    int          exp_base;
    int          calc_cnt;
    int          calc_avg;
    bit          tb_armed;
    int          armed_idx;
    logic [31:0] exp_ts_q [$];
    int          exp_lane_q [$];
    int          exp_sample_q [$];
    logic [31:0] exp_ts;
    int          exp_lane;
    int          exp_sample;
    int          errors;
    int          checks;
    int          events_seen;
    int          events_expected;

    adc_trigger_top adc_trigger_top_inst (
        .AXIS_ACLK         (AXIS_ACLK),
        .AXIS_ARESETN      (AXIS_ARESETN),
        .s_axis_tdata      (s_axis_tdata),
        .s_axis_tvalid     (s_axis_tvalid),
        .s_axis_tready     (s_axis_tready),
        .start             (start),
        .arm               (arm),
        .baseline          (baseline),
        .calc_complete     (calc_complete),
        .m_event_valid     (m_event_valid),
        .m_event_ready     (m_event_ready),
        .m_event_timestamp (m_event_timestamp),
        .m_event_lane      (m_event_lane),
        .m_event_sample    (m_event_sample)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
    end

    always #5 AXIS_ACLK = ~AXIS_ACLK;

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic add_phase(input int i, input string name, input bit do_start,
                             input bit do_arm, input int level, input int noise,
                             input int beats, input logic [7:0] mask, input int off,
                             input int at, input int cnt, input bit hold, input bit gaps);
        ph_name[i]      = name;
        ph_start[i]     = do_start;
        ph_arm[i]       = do_arm;
        ph_level[i]     = level;
        ph_noise[i]     = noise;
        ph_beats[i]     = beats;
        ph_mask[i]      = mask;
        ph_spike_off[i] = off;
        ph_spike_at[i]  = at;
        ph_spike_cnt[i] = cnt;
        ph_hold[i]      = hold;
        ph_gaps[i]      = gaps;
        total_beats     = total_beats + beats;
    endtask

    task automatic load_table();
        total_beats = 0;
        // name, start, arm, level, noise, beats, mask, offset, at, count, hold, gaps
        add_phase(0, "calc_a", 1, 0, 1000, 31, 16, 8'h00, 0, 0, 0, 0, 1);
        add_phase(1, "armed_hit", 0, 1, 1000, 31, 12, 8'h24, 600, 7, 1, 0, 0);
        add_phase(2, "at_limit", 0, 1, 1000, 31, 6, 8'hff, HIT_MARGIN, 0, 6, 0, 1);
        add_phase(3, "backpressure", 0, 1, 1000, 31, 10, 8'h10, 500, 2, 6, 1, 0);
        add_phase(4, "disarmed", 0, 0, 1000, 31, 6, 8'h01, 800, 0, 6, 0, 0);
        add_phase(5, "calc_b", 1, 0, 2000, 63, 16, 8'h00, 0, 0, 0, 0, 1);
        add_phase(6, "armed_b", 0, 1, 2000, 63, 8, 8'h80, 700, 3, 1, 0, 0);
        table_ready = 1'b1;
    endtask

    // noisy lanes, spikes sit relative to the expected baseline
    task automatic build_beat(input int p, input int b, output logic [TDATA_WIDTH-1:0] data);
        logic [31:0] r;
        int          s;
        data = '0;
        for (int l = 0; l < LANES; l++)
        begin
            r = next_random();
            s = ph_level[p] + int'((r >> 8) % (ph_noise[p] + 1));
            if (ph_mask[p][l] && b >= ph_spike_at[p] && b < ph_spike_at[p] + ph_spike_cnt[p])
                s = exp_base + ph_spike_off[p];
            data[l*LANE_WIDTH +: ADC_WIDTH] = s[ADC_WIDTH-1:0];
            // junk above the sample bits
            data[l*LANE_WIDTH+ADC_WIDTH +: 4] = r[3:0];
        end
    endtask

    task automatic model_accept(input int p, input logic [TDATA_WIDTH-1:0] data);
        int sum;
        int v;
        int lane;
        int smp;
        sum  = 0;
        lane = -1;
        smp  = 0;
        for (int l = 0; l < LANES; l++)
        begin
            v   = int'(data[l*LANE_WIDTH +: ADC_WIDTH]);
            sum = sum + v;
            if (lane < 0 && v > exp_base + HIT_MARGIN)
            begin
                lane = l;
                smp  = v;
            end
        end
        if (ph_start[p] && calc_cnt < CALC_LEN)
        begin
            if (calc_cnt == 0)
                calc_avg = sum / 8;
            else
                calc_avg = calc_avg / 2 + sum / 16;
            calc_cnt++;
            if (calc_cnt == CALC_LEN)
                exp_base = calc_avg;
        end
        if (tb_armed)
        begin
            if (lane >= 0)
            begin
                exp_ts_q.push_back(armed_idx);
                exp_lane_q.push_back(lane);
                exp_sample_q.push_back(smp);
                events_expected++;
            end
            armed_idx++;
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic run_phase(input int p);
        logic [TDATA_WIDTH-1:0] data;
        int                     stall;
        bit                     stall_seen;
        bit                     accepted;
        cur_name   = ph_name[p];
        stall      = 0;
        stall_seen = 0;
        if (ph_arm[p] && !arm)
            armed_idx = 0;
        arm           = ph_arm[p];
        m_event_ready = !ph_hold[p];
        if (ph_start[p])
        begin
            start    = 1'b1;
            calc_cnt = 0;
            @(posedge AXIS_ACLK);
            #1;
            start = 1'b0;
        end
        else
        begin
            repeat (3) @(posedge AXIS_ACLK);
            #1;
        end
        tb_armed = ph_arm[p];
        for (int b = 0; b < ph_beats[p]; b++)
        begin
            if (ph_gaps[p] && (b % 2 == 1))
            begin
                s_axis_tvalid = 1'b0;
                @(posedge AXIS_ACLK);
                #1;
            end
            build_beat(p, b, data);
            s_axis_tdata  = data;
            s_axis_tvalid = 1'b1;
            accepted      = 1'b0;
            while (!accepted)
            begin
                @(negedge AXIS_ACLK);
                if (ph_start[p] && b == 1)
                begin
                    checks++;
                    if (calc_complete !== 1'b0)
                    begin
                        errors++;
                        $display("error %s calc_complete: expected 0, actual %0d",
                                 cur_name, calc_complete);
                    end
                end
                accepted = s_axis_tready;
                if (accepted)
                    model_accept(p, data);
                @(posedge AXIS_ACLK);
                #1;
                if (!accepted)
                begin
                    stall_seen = 1'b1;
                    stall++;
                    // let the queue drain after a short stall
                    if (stall >= 3)
                        m_event_ready = 1'b1;
                end
            end
        end
        s_axis_tvalid = 1'b0;
        m_event_ready = 1'b1;
        if (ph_hold[p])
        begin
            checks++;
            if (!stall_seen)
            begin
                errors++;
                $display("%s: s_axis_tready never fell while event ready was low", cur_name);
            end
        end
        if (ph_start[p])
        begin
            wait (calc_complete === 1'b1);
            @(negedge AXIS_ACLK);
            checks++;
            if (baseline !== exp_base[ADC_WIDTH-1:0])
            begin
                errors++;
                $display("error %s baseline: expected %0d, actual %0d",
                         cur_name, exp_base, baseline);
            end
            @(posedge AXIS_ACLK);
            #1;
        end
        while (exp_ts_q.size() != 0)
            @(posedge AXIS_ACLK);
        // idle tail catches stray events
        repeat (4) @(posedge AXIS_ACLK);
        #1;
    endtask

    // event handover happens at the next rising edge
    always @(negedge AXIS_ACLK)
    begin
        if (AXIS_ARESETN && m_event_valid && m_event_ready)
        begin
            events_seen++;
            checks++;
            if (exp_ts_q.size() == 0)
            begin
                errors++;
                $display("unexpected event during %s, lane %0d timestamp %0d",
                         cur_name, m_event_lane, m_event_timestamp);
            end
            else
            begin
                exp_ts     = exp_ts_q.pop_front();
                exp_lane   = exp_lane_q.pop_front();
                exp_sample = exp_sample_q.pop_front();
                if (m_event_timestamp !== exp_ts)
                begin
                    errors++;
                    $display("error %s timestamp: expected %0d, actual %0d",
                             cur_name, exp_ts, m_event_timestamp);
                end
                if (m_event_lane !== exp_lane[2:0])
                begin
                    errors++;
                    $display("error %s lane: expected %0d, actual %0d",
                             cur_name, exp_lane, m_event_lane);
                end
                if (m_event_sample !== exp_sample[ADC_WIDTH-1:0])
                begin
                    errors++;
                    $display("error %s sample: expected %0d, actual %0d",
                             cur_name, exp_sample, m_event_sample);
                end
            end
        end
    end

    initial
    begin
        wait (table_ready);
        repeat (total_beats * 4 + 200) @(posedge AXIS_ACLK);
        $display("timeout: run did not finish within %0d cycles", total_beats * 4 + 200);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        seed            = 32'h21585d2f;
        errors          = 0;
        checks          = 0;
        events_seen     = 0;
        events_expected = 0;
        exp_base        = 0;
        calc_cnt        = 0;
        calc_avg        = 0;
        tb_armed        = 1'b0;
        armed_idx       = 0;
        cur_name        = "reset";
        AXIS_ARESETN    = 1'b0;
        s_axis_tdata    = '0;
        s_axis_tvalid   = 1'b0;
        start           = 1'b0;
        arm             = 1'b0;
        m_event_ready   = 1'b1;
        load_table();
        repeat (8) @(posedge AXIS_ACLK);
        #1;
        AXIS_ARESETN = 1'b1;
        @(negedge AXIS_ACLK);
        checks = checks + 3;
        if (calc_complete !== 1'b0)
        begin
            errors++;
            $display("error reset calc_complete: expected 0, actual %0d", calc_complete);
        end
        if (m_event_valid !== 1'b0)
        begin
            errors++;
            $display("error reset m_event_valid: expected 0, actual %0d", m_event_valid);
        end
        if (s_axis_tready !== 1'b1)
        begin
            errors++;
            $display("error reset s_axis_tready: expected 1, actual %0d", s_axis_tready);
        end
        @(posedge AXIS_ACLK);
        #1;
        for (int p = 0; p < NUM_PHASES; p++)
            run_phase(p);
        cur_name = "summary";
        checks++;
        if (events_seen != events_expected)
        begin
            errors++;
            $display("error %s event count: expected %0d, actual %0d",
                     cur_name, events_expected, events_seen);
        end
        $display("checks %0d, errors %0d, events %0d", checks, errors, events_seen);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== threshold_detect.sv ====
`timescale 1ns/10ps

module threshold_detect (
    input  logic                                 AXIS_ACLK,
    input  logic                                 AXIS_ARESETN,
    input  adc_trig_pkg::exec_state_t            exec_state,
    input  logic [adc_trig_pkg::TDATA_WIDTH-1:0] tdata,
    input  logic                                 tvalid,
    output logic                                 tready,
    input  adc_trig_pkg::sample_t                baseline,
    trig_event_if.src                            evt
);
    import adc_trig_pkg::*;

    logic               armed;
    logic               accept;
    logic               load;
    logic [ADC_WIDTH:0] limit;
    logic [LANES-1:0]   hit;
    lane_idx_t          hit_lane;
    sample_t            hit_sample;
    timestamp_t         ts_cnt;

    assign armed = (exec_state == EXEC_TRG);

    // stall only when armed and the event register cannot take a new hit
    assign tready = !armed || !evt.valid || evt.ready;
    assign accept = tvalid && tready;

    // extra bit keeps baseline plus threshold from wrapping
    assign limit = {1'b0, baseline} + (ADC_WIDTH + 1)'(THRESHOLD_COUNTS);

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
        begin
            hit[i] = {1'b0, tdata[i*LANE_WIDTH +: ADC_WIDTH]} > limit;
        end
    end

    // downward scan so the lowest hit lane wins
    always_comb
    begin
        hit_lane   = '0;
        hit_sample = '0;
        for (int i = LANES - 1; i >= 0; i--)
        begin
            if (hit[i])
            begin
                hit_lane   = lane_idx_t'(i);
                hit_sample = tdata[i*LANE_WIDTH +: ADC_WIDTH];
            end
        end
    end

    assign load = accept && armed && (|hit);

    // beat index since arming, first armed beat is 0
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            ts_cnt <= '0;
        else if (!armed)
            ts_cnt <= '0;
        else if (accept)
            ts_cnt <= ts_cnt + 1'b1;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
            evt.valid <= 1'b0;
        else if (load)
            evt.valid <= 1'b1;
        else if (evt.ready)
            evt.valid <= 1'b0;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (load)
        begin
            evt.timestamp <= ts_cnt;
            evt.lane      <= hit_lane;
            evt.sample    <= hit_sample;
        end
    end

    a_evt_hold : assert property (
        @(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (evt.valid && !evt.ready) |=> (evt.valid && $stable(evt.timestamp) &&
                                       $stable(evt.lane) && $stable(evt.sample))
    );

endmodule

// ==== trig_event_if.sv ====
`timescale 1ns/10ps

interface trig_event_if;
    import adc_trig_pkg::*;

    // one trigger event with valid/ready handshake
    logic       valid;
    logic       ready;
    timestamp_t timestamp;
    lane_idx_t  lane;
    sample_t    sample;

    // detector side
    modport src (
        output valid,
        output timestamp,
        output lane,
        output sample,
        input  ready
    );

    // queue side
    modport dst (
        input  valid,
        input  timestamp,
        input  lane,
        input  sample,
        output ready
    );

endinterface
